// File: logic/jtag_pkg.sv
package jtag_pkg;

  ////////////////////////////////////////
  // TAP controller states
  ////////////////////////////////////////

  // Standard 1149.1 state encoding
  typedef enum logic [3:0] {
    exit2_dr         = 4'h0,
    exit1_dr         = 4'h1,
    shift_dr         = 4'h2,
    pause_dr         = 4'h3,
    select_ir_scan   = 4'h4,
    update_dr        = 4'h5,
    capture_dr       = 4'h6,
    select_dr_scan   = 4'h7,
    exit2_ir         = 4'h8,
    exit1_ir         = 4'h9,
    shift_ir         = 4'hA,
    pause_ir         = 4'hB,
    run_test_idle    = 4'hC,
    update_ir        = 4'hD,
    capture_ir       = 4'hE,
    test_logic_reset = 4'hF
  } tap_state_t;

  ////////////////////////////////////////
  // Instructions and identification
  ////////////////////////////////////////

  localparam int INSTR_W = 5;

  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [31:0]        idcode_t;

  localparam instr_t OP_BYPASS  = 5'b11111;
  localparam instr_t OP_IDCODE  = 5'b00001;
  localparam instr_t OP_SAMPLE  = 5'b00010;
  localparam instr_t OP_PRELOAD = 5'b00011;
  localparam instr_t OP_EXTEST  = 5'b00101;

  // Fixed pattern seen in Capture-IR, low bits 01 as required
  localparam instr_t IR_CAPTURE = 5'b00001;

  localparam idcode_t DEFAULT_IDCODE = 32'hDEADBEEF;

endpackage

// File: logic/tap_fsm.sv
`timescale 1ns/1ps

module tap_fsm (
  input  logic                 tck,
  input  logic                 rst_n,
  input  logic                 tms_i,
  output jtag_pkg::tap_state_t state_o,
  output logic                 capture_dr_o,
  output logic                 shift_dr_o,
  output logic                 update_dr_o,
  output logic                 capture_ir_o,
  output logic                 shift_ir_o,
  output logic                 update_ir_o,
  output logic                 tlr_o
);

  import jtag_pkg::*;

  tap_state_t state_q;
  tap_state_t state_d;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    unique case (state_q)
      test_logic_reset: state_d = tms_i ? test_logic_reset : run_test_idle;
      run_test_idle:    state_d = tms_i ? select_dr_scan   : run_test_idle;

      // DR branch
      select_dr_scan:   state_d = tms_i ? select_ir_scan   : capture_dr;
      capture_dr:       state_d = tms_i ? exit1_dr         : shift_dr;
      shift_dr:         state_d = tms_i ? exit1_dr         : shift_dr;
      exit1_dr:         state_d = tms_i ? update_dr        : pause_dr;
      pause_dr:         state_d = tms_i ? exit2_dr         : pause_dr;
      exit2_dr:         state_d = tms_i ? update_dr        : shift_dr;
      update_dr:        state_d = tms_i ? select_dr_scan   : run_test_idle;

      // IR branch, TMS high here falls back to reset
      select_ir_scan:   state_d = tms_i ? test_logic_reset : capture_ir;
      capture_ir:       state_d = tms_i ? exit1_ir         : shift_ir;
      shift_ir:         state_d = tms_i ? exit1_ir         : shift_ir;
      exit1_ir:         state_d = tms_i ? update_ir        : pause_ir;
      pause_ir:         state_d = tms_i ? exit2_ir         : pause_ir;
      exit2_ir:         state_d = tms_i ? update_ir        : shift_ir;
      update_ir:        state_d = tms_i ? select_dr_scan   : run_test_idle;
      default:          state_d = test_logic_reset;
    endcase
  end

  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= test_logic_reset;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // State strobes
  ////////////////////////////////////////

  assign state_o      = state_q;
  assign capture_dr_o = (state_q == capture_dr);
  assign shift_dr_o   = (state_q == shift_dr);
  assign update_dr_o  = (state_q == update_dr);
  assign capture_ir_o = (state_q == capture_ir);
  assign shift_ir_o   = (state_q == shift_ir);
  assign update_ir_o  = (state_q == update_ir);
  assign tlr_o        = (state_q == test_logic_reset);

  // Controller leaves reset sitting in Test-Logic-Reset
  a_reset_state: assert property (
    @(posedge tck) $rose(rst_n) |-> state_q == test_logic_reset
  );

  // Five TMS ones reach reset from anywhere
  a_tms_reset: assert property (
    @(posedge tck) disable iff (!rst_n)
    tms_i [*5] |=> state_q == test_logic_reset
  );

endmodule

// File: logic/tap_ir.sv
`timescale 1ns/1ps

module tap_ir (
  input  logic tck,
  input  logic rst_n,
  input  logic tdi_i,
  input  logic capture_ir_i,
  input  logic shift_ir_i,
  input  logic update_ir_i,
  input  logic tlr_i,
  output logic ir_tdo_o,
  output logic bypass_sel_o,
  output logic idcode_sel_o,
  output logic bsr_sel_o,
  output logic extest_o
);

  import jtag_pkg::*;

  instr_t ir_shift_q;
  instr_t instr_q;

  // Shift stage, tdi enters at the top
  always_ff @(posedge tck) begin
    if (capture_ir_i) begin
      ir_shift_q <= IR_CAPTURE;
    end else if (shift_ir_i) begin
      ir_shift_q <= {tdi_i, ir_shift_q[INSTR_W-1:1]};
    end
  end

  assign ir_tdo_o = ir_shift_q[0];

  // Instruction latch on the falling edge
  always_ff @(negedge tck or negedge rst_n) begin
    if (!rst_n) begin
      instr_q <= OP_IDCODE;
    end else if (tlr_i) begin
      instr_q <= OP_IDCODE;
    end else if (update_ir_i) begin
      instr_q <= ir_shift_q;
    end
  end

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  always_comb begin
    bypass_sel_o = 1'b0;
    idcode_sel_o = 1'b0;
    bsr_sel_o    = 1'b0;
    extest_o     = 1'b0;
    case (instr_q)
      OP_IDCODE:              idcode_sel_o = 1'b1;
      OP_SAMPLE, OP_PRELOAD:  bsr_sel_o    = 1'b1;
      OP_EXTEST: begin
        bsr_sel_o = 1'b1;
        extest_o  = 1'b1;
      end
      // BYPASS and every unknown opcode
      default:                bypass_sel_o = 1'b1;
    endcase
  end

  a_one_sel: assert property (
    @(posedge tck) disable iff (!rst_n)
    $onehot({bypass_sel_o, idcode_sel_o, bsr_sel_o})
  );

endmodule

// File: logic/bsr_cell.sv
`timescale 1ns/1ps

module bsr_cell (
  input  logic tck,
  input  logic rst_n,
  input  logic capture_i,
  input  logic shift_i,
  input  logic update_i,
  input  logic bsr_sel_i,
  input  logic extest_i,
  input  logic scan_i,
  input  logic pin_i,
  input  logic core_i,
  output logic scan_o,
  output logic pin_o
);

  logic capture_q;
  logic update_q;

  // Capture/shift stage
  always_ff @(posedge tck) begin
    if (bsr_sel_i) begin
      if (capture_i) begin
        capture_q <= pin_i;
      end else if (shift_i) begin
        capture_q <= scan_i;
      end
    end
  end

  // Update stage, stable while shifting
  always_ff @(negedge tck or negedge rst_n) begin
    if (!rst_n) begin
      update_q <= 1'b0;
    end else if (update_i && bsr_sel_i) begin
      update_q <= capture_q;
    end
  end

  assign scan_o = capture_q;
  assign pin_o  = extest_i ? update_q : core_i;

  a_cap_shift: assert property (
    @(posedge tck) disable iff (!rst_n) !(capture_i && shift_i)
  );

endmodule

// File: logic/tap_tdo_path.sv
`timescale 1ns/1ps

module tap_tdo_path #(
  parameter jtag_pkg::idcode_t IDCODE_VALUE = jtag_pkg::DEFAULT_IDCODE
) (
  input  logic tck,
  input  logic rst_n,
  input  logic tdi_i,
  input  logic capture_dr_i,
  input  logic shift_dr_i,
  input  logic shift_ir_i,
  input  logic tlr_i,
  input  logic bypass_sel_i,
  input  logic idcode_sel_i,
  input  logic bsr_sel_i,
  input  logic ir_tdo_i,
  input  logic bsr_tdo_i,
  output logic tdo_o
);

  import jtag_pkg::*;

  logic    bypass_q;
  idcode_t idcode_q;
  logic    tdo_d;
  logic    tdo_q;

  ////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////

  // Bypass captures a zero
  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      bypass_q <= 1'b0;
    end else if (tlr_i) begin
      bypass_q <= 1'b0;
    end else if (bypass_sel_i) begin
      if (capture_dr_i) begin
        bypass_q <= 1'b0;
      end else if (shift_dr_i) begin
        bypass_q <= tdi_i;
      end
    end
  end

  always_ff @(posedge tck) begin
    if (idcode_sel_i) begin
      if (capture_dr_i) begin
        idcode_q <= IDCODE_VALUE;
      end else if (shift_dr_i) begin
        idcode_q <= {tdi_i, idcode_q[$bits(idcode_t)-1:1]};
      end
    end
  end

  ////////////////////////////////////////
  // TDO select and output flop
  ////////////////////////////////////////

  always_comb begin
    if (shift_ir_i) begin
      tdo_d = ir_tdo_i;
    end else if (bypass_sel_i) begin
      tdo_d = bypass_q;
    end else if (idcode_sel_i) begin
      tdo_d = idcode_q[0];
    end else if (bsr_sel_i) begin
      tdo_d = bsr_tdo_i;
    end else begin
      tdo_d = 1'b0;
    end
  end

  // Falling edge, half a cycle after the shift
  always_ff @(negedge tck or negedge rst_n) begin
    if (!rst_n) begin
      tdo_q <= 1'b0;
    end else if (shift_ir_i || shift_dr_i) begin
      tdo_q <= tdo_d;
    end
  end

  assign tdo_o = tdo_q;

endmodule

// File: logic/jtag_tap_top.sv
`timescale 1ns/1ps

module jtag_tap_top #(
  parameter int                N_CELLS      = 8,
  parameter jtag_pkg::idcode_t IDCODE_VALUE = jtag_pkg::DEFAULT_IDCODE
) (
  input  logic               tck,
  input  logic               rst_n,
  input  logic               tms_i,
  input  logic               tdi_i,
  input  logic [N_CELLS-1:0] pin_i,
  input  logic [N_CELLS-1:0] core_i,
  output logic               tdo_o,
  output logic [N_CELLS-1:0] pin_o
);

  logic cap_dr;
  logic sh_dr;
  logic upd_dr;
  logic cap_ir;
  logic sh_ir;
  logic upd_ir;
  logic tlr;
  logic ir_tdo;
  logic bypass_sel;
  logic idcode_sel;
  logic bsr_sel;
  logic extest;

  // tdi enters at the top, cell 0 drains to TDO
  logic [N_CELLS:0] scan_chain;

  ////////////////////////////////////////
  // Controller and instruction register
  ////////////////////////////////////////

  tap_fsm tap_fsm_inst (
    .tck          (tck),
    .rst_n        (rst_n),
    .tms_i        (tms_i),
    .state_o      (),
    .capture_dr_o (cap_dr),
    .shift_dr_o   (sh_dr),
    .update_dr_o  (upd_dr),
    .capture_ir_o (cap_ir),
    .shift_ir_o   (sh_ir),
    .update_ir_o  (upd_ir),
    .tlr_o        (tlr)
  );

  tap_ir tap_ir_inst (
    .tck          (tck),
    .rst_n        (rst_n),
    .tdi_i        (tdi_i),
    .capture_ir_i (cap_ir),
    .shift_ir_i   (sh_ir),
    .update_ir_i  (upd_ir),
    .tlr_i        (tlr),
    .ir_tdo_o     (ir_tdo),
    .bypass_sel_o (bypass_sel),
    .idcode_sel_o (idcode_sel),
    .bsr_sel_o    (bsr_sel),
    .extest_o     (extest)
  );

  ////////////////////////////////////////
  // Boundary-scan chain
  ////////////////////////////////////////

  assign scan_chain[N_CELLS] = tdi_i;

  for (genvar k = 0; k < N_CELLS; k++) begin : g_cell
    bsr_cell bsr_cell_inst (
      .tck       (tck),
      .rst_n     (rst_n),
      .capture_i (cap_dr),
      .shift_i   (sh_dr),
      .update_i  (upd_dr),
      .bsr_sel_i (bsr_sel),
      .extest_i  (extest),
      .scan_i    (scan_chain[k+1]),
      .pin_i     (pin_i[k]),
      .core_i    (core_i[k]),
      .scan_o    (scan_chain[k]),
      .pin_o     (pin_o[k])
    );
  end

  tap_tdo_path #(
    .IDCODE_VALUE (IDCODE_VALUE)
  ) tap_tdo_path_inst (
    .tck          (tck),
    .rst_n        (rst_n),
    .tdi_i        (tdi_i),
    .capture_dr_i (cap_dr),
    .shift_dr_i   (sh_dr),
    .shift_ir_i   (sh_ir),
    .tlr_i        (tlr),
    .bypass_sel_i (bypass_sel),
    .idcode_sel_i (idcode_sel),
    .bsr_sel_i    (bsr_sel),
    .ir_tdo_i     (ir_tdo),
    .bsr_tdo_i    (scan_chain[0]),
    .tdo_o        (tdo_o)
  );

endmodule

// File: bench/tap_tb.sv
`timescale 1ns/1ps

module tap_tb;

  import jtag_pkg::*;

  localparam int N_CELLS = 8;

  logic               tck;
  logic               rst_n;
  logic               tms_i;
  logic               tdi_i;
  logic [N_CELLS-1:0] pin_i;
  logic [N_CELLS-1:0] core_i;
  logic               tdo_o;
  logic [N_CELLS-1:0] pin_o;

  string      lines[$];
  string      line;
  string      name;
  logic [7:0] op;
  logic       b;
  int         fd;
  int         n;
  int         len;
  int         seed   = 58889;
  int         cycles = 0;
  int         limit  = 20;
  int         n_pass = 0;
  int         n_fail = 0;
  bit         err;

  jtag_tap_top #(
    .N_CELLS (N_CELLS)
  ) jtag_tap_top_inst (
    .tck    (tck),
    .rst_n  (rst_n),
    .tms_i  (tms_i),
    .tdi_i  (tdi_i),
    .pin_i  (pin_i),
    .core_i (core_i),
    .tdo_o  (tdo_o),
    .pin_o  (pin_o)
  );

  initial begin
    tck = 1'b0;
    forever #5 tck = ~tck;
  end

  always @(posedge tck) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, the TAP scans never completed", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // JTAG pin sequencing
  ////////////////////////////////////////

  // TDO is read before the edge, TMS and TDI set up for the next one
  task automatic step(input logic tms, input logic tdi, output logic tdo);
    @(posedge tck);
    tdo = tdo_o;
    tms_i <= tms;
    tdi_i <= tdi;
  endtask

  // Starts and ends in Run-Test/Idle, LSB first
  task automatic scan(input bit is_ir, input int len, input idcode_t din,
                      output idcode_t dout);
    logic bit_q;
    dout = '0;
    step(1'b1, 1'b0, bit_q);
    if (is_ir) begin
      step(1'b1, 1'b0, bit_q);
    end
    step(1'b0, 1'b0, bit_q);
    step(1'b0, 1'b0, bit_q);
    for (int i = 0; i < len; i++) begin
      step(i == len - 1, din[i], bit_q);
      if (i > 0) begin
        dout[i-1] = bit_q;
      end
    end
    // Exit1, Update, back to idle
    step(1'b1, 1'b0, bit_q);
    dout[len-1] = bit_q;
    step(1'b0, 1'b0, bit_q);
    step(1'b0, 1'b0, bit_q);
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_ir(input string tname, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      if (!err) begin
        $display("Fail %s: IR capture expected %h, got %h", tname, exp, act);
      end
      err = 1'b1;
    end
  endtask

  task automatic check_dr(input string tname, input idcode_t exp, input idcode_t act);
    if (act !== exp) begin
      if (!err) begin
        $display("Fail %s: TDO data expected %h, got %h", tname, exp, act);
      end
      err = 1'b1;
    end
  endtask

  task automatic check_pins(input string tname, input logic [N_CELLS-1:0] exp,
                            input logic [N_CELLS-1:0] act);
    if (act !== exp) begin
      if (!err) begin
        $display("Fail %s: pin_o expected %h, got %h", tname, exp, act);
      end
      err = 1'b1;
    end
  endtask

  task automatic run_test(input string vec);
    string              tname;
    string              tdi_tok;
    string              exp_tok;
    logic [7:0]         top;
    int                 tlen;
    int                 cnt;
    idcode_t            tdi;
    idcode_t            exp_tdo;
    idcode_t            mask;
    idcode_t            dout;
    logic [N_CELLS-1:0] pins;
    logic [N_CELLS-1:0] cores;
    logic [N_CELLS-1:0] exp_pin;
    logic               bit_q;
    err = 1'b0;
    cnt = $sscanf(vec, "%s %h %d %s %h %h %s %h",
                  tname, top, tlen, tdi_tok, pins, cores, exp_tok, exp_pin);
    if (cnt != 8) begin
      $display("Vector line could not be parsed: %s", vec);
      n_fail++;
    end else begin
      mask = (tlen >= 32) ? '1 : ((idcode_t'(1) << tlen) - 1);
      if (tdi_tok == "r") begin
        // Random data only on bypass lines, zero first then tdi one bit late
        tdi     = $random(seed) & mask;
        exp_tdo = (tdi << 1) & mask;
      end else begin
        cnt = $sscanf(tdi_tok, "%h", tdi);
        cnt = $sscanf(exp_tok, "%h", exp_tdo);
      end
      @(posedge tck);
      pin_i  <= pins;
      core_i <= cores;
      if (top == 8'h40) begin
        repeat (5) step(1'b1, 1'b0, bit_q);
        step(1'b0, 1'b0, bit_q);
      end else if (top < 8'h20) begin
        scan(1'b1, INSTR_W, idcode_t'(top[INSTR_W-1:0]), dout);
        check_ir(tname, IR_CAPTURE, dout[INSTR_W-1:0]);
      end
      if (tlen > 0) begin
        scan(1'b0, tlen, tdi, dout);
        check_dr(tname, exp_tdo & mask, dout & mask);
      end
      step(1'b0, 1'b0, bit_q);
      check_pins(tname, exp_pin, pin_o);
      if (err) begin
        n_fail++;
      end else begin
        n_pass++;
        $display("Pass %s", tname);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n  = 1'b0;
    tms_i  = 1'b1;
    tdi_i  = 1'b0;
    pin_i  = '0;
    core_i = '0;
    fd = $fopen("bench/tap_vectors.txt", "r");
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        lines.push_back(line);
        if ($sscanf(line, "%s %h %d", name, op, len) == 3) begin
          limit += (len + 30) * 2;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (lines.size() == 0) begin
      $display("No test vectors were read from bench/tap_vectors.txt");
      n_fail++;
    end
    repeat (4) @(posedge tck);
    rst_n <= 1'b1;
    step(1'b0, 1'b0, b);
    foreach (lines[i]) begin
      run_test(lines[i]);
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: bench/tap_vectors.txt
# name op len tdi pin_i core_i exp_tdo exp_pin (all hex except len)
# op 20 keeps the instruction, op 40 walks five TMS ones, tdi r draws bypass data
idcode_reset   20 32 0    a5 3c deadbeef 3c
ir_capture     01 32 0    a5 3c deadbeef 3c
bypass         1f 16 b3c1 00 00 6782     00
bypass_random  1f 24 r    00 ff r        ff
unknown_op     08 12 5a5  00 0f b4a      0f
sample         02 8  00   c6 39 c6       39
preload        03 8  a7   5e 11 5e       11
extest         05 0  0    5e 11 0        a7
extest_core    20 0  0    5e 6b 0        a7
extest_scan    20 8  3d   81 6b 81       3d
tms_reset      40 32 0    81 6b deadbeef 6b

// File: sim.f
logic/jtag_pkg.sv
logic/tap_fsm.sv
logic/tap_ir.sv
logic/bsr_cell.sv
logic/tap_tdo_path.sv
logic/jtag_tap_top.sv
bench/tap_tb.sv
